// File: include/store_buffer_config.svh
`ifndef STORE_BUFFER_CONFIG_SVH
`define STORE_BUFFER_CONFIG_SVH

// number of lines as a power of two from 4 to 64.
`define SB_DEPTH 8

// width of the line index in address bits index+2 down to 3.
`define SB_INDEX_WIDTH $clog2(`SB_DEPTH)

// the whole line address (bits 31 down to 3) is kept as the tag.
`define SB_TAG_WIDTH 29

`endif

// File: hw/store_buffer_pkg.sv
`include "store_buffer_config.svh"

package store_buffer_pkg;

    typedef logic [`SB_INDEX_WIDTH-1:0] sb_index_t;

    // ######################################################################
    // processor side.
    // ######################################################################

    typedef struct packed {
        logic        valid;     // one-cycle strobe.
        logic        fence;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  strb;      // all zero for a load.
    } sb_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        ready;
    } sb_rsp_t;

    // ######################################################################
    // data memory side.
    // ######################################################################

    typedef struct packed {
        logic        valid;     // held until memory answers.
        logic        store;
        logic [31:0] addr;
        logic [63:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        ready;
    } mem_rsp_t;

    // one stored line of 95 bits at the default widths.
    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`SB_TAG_WIDTH-1:0] tag;
        logic [63:0]              data;
    } sb_line_t;

    typedef struct packed {
        sb_index_t [1:0] raddr;
        logic [1:0]      wen;
        sb_index_t [1:0] waddr;
        sb_line_t [1:0]  wdata;
    } sb_array_in_t;

    typedef struct packed {
        sb_line_t [1:0] rdata;
    } sb_array_out_t;

endpackage

// File: hw/store_buffer_array.sv
`timescale 1ns/1ps
`include "store_buffer_config.svh"

module store_buffer_array (
    input  logic                           clock,
    input  store_buffer_pkg::sb_array_in_t array_in,
    output store_buffer_pkg::sb_array_out_t array_out
);
    import store_buffer_pkg::*;

    sb_line_t lines [`SB_DEPTH] = '{default: '0};

    // port 1 is written last, so it wins on a shared index.
    always_ff @(posedge clock) begin
        for (int p = 0; p < 2; p++) begin
            if (array_in.wen[p]) begin
                lines[array_in.waddr[p]] <= array_in.wdata[p];
            end
        end
    end

    // reads see this cycle's writes with port 0 checked first.
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (array_in.wen[0] && array_in.waddr[0] == array_in.raddr[p]) begin
                array_out.rdata[p] = array_in.wdata[0];
            end else if (array_in.wen[1] && array_in.waddr[1] == array_in.raddr[p]) begin
                array_out.rdata[p] = array_in.wdata[1];
            end else begin
                array_out.rdata[p] = lines[array_in.raddr[p]];
            end
        end
    end

endmodule

// File: hw/store_buffer_ctrl.sv
`timescale 1ns/1ps
`include "store_buffer_config.svh"

module store_buffer_ctrl (
    input  logic                            clock,
    input  logic                            reset,
    input  store_buffer_pkg::sb_req_t       port0_req,
    input  store_buffer_pkg::sb_req_t       port1_req,
    output store_buffer_pkg::sb_rsp_t       port0_rsp,
    output store_buffer_pkg::sb_rsp_t       port1_rsp,
    input  store_buffer_pkg::sb_array_out_t array_out,
    output store_buffer_pkg::sb_array_in_t  array_in,
    input  store_buffer_pkg::mem_rsp_t      mem0_rsp,
    input  store_buffer_pkg::mem_rsp_t      mem1_rsp,
    output store_buffer_pkg::mem_req_t      mem0_req,
    output store_buffer_pkg::mem_req_t      mem1_req
);
    import store_buffer_pkg::*;

    typedef struct packed {
        logic        retry;     // miss parked until the back stage is free.
        logic        wait_ret;  // memory work handed off.
        logic        fence;     // walk in progress.
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        sb_index_t   walk;
        logic        wen;       // line write applied one cycle later.
        sb_index_t   waddr;
        sb_line_t    wline;
        logic        ready;
        logic [63:0] rdata;
    } front_t;

    typedef struct packed {
        logic        miss;      // refill pending.
        logic        back;      // writeback pending and served first.
        logic [31:0] fill_addr;
        logic [31:0] vict_addr;
        logic [63:0] vict_data;
    } back_t;

    front_t [1:0] r_f, rin_f;
    back_t [1:0]  r_b, rin_b;

    sb_req_t [1:0]  req;
    mem_rsp_t [1:0] mrsp;
    sb_rsp_t [1:0]  prsp;
    mem_req_t [1:0] mreq;

    logic [1:0]     ret;        // back stage done so the access completes.
    sb_line_t [1:0] fill;
    logic [1:0]     start;
    back_t [1:0]    work;
    logic           back_idle;

    assign req  = {port1_req, port0_req};
    assign mrsp = {mem1_rsp, mem0_rsp};

    assign port0_rsp = prsp[0];
    assign port1_rsp = prsp[1];
    assign mem0_req  = mreq[0];
    assign mem1_req  = mreq[1];

    assign back_idle = ~|{r_b[1].miss, r_b[1].back, r_b[0].miss, r_b[0].back};

    // ######################################################################
    // storage access
    // ######################################################################

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (r_f[p].fence) begin
                array_in.raddr[p] = r_f[p].walk;
            end else if (r_f[p].retry || r_f[p].wait_ret) begin
                array_in.raddr[p] = r_f[p].addr[`SB_INDEX_WIDTH+2:3];
            end else begin
                array_in.raddr[p] = req[p].addr[`SB_INDEX_WIDTH+2:3];
            end
            array_in.wen[p]   = r_f[p].wen;
            array_in.waddr[p] = r_f[p].waddr;
            array_in.wdata[p] = r_f[p].wline;
        end
    end

    // memory answers for the back stage.
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            fill[p] = '{valid: 1'b1, dirty: 1'b0, tag: r_b[p].fill_addr[31:3],
                        data: mrsp[p].rdata};
            ret[p] = mrsp[p].ready & (r_b[p].back ? ~r_b[p].miss : r_b[p].miss);
        end
    end

    // ######################################################################
    // front stage
    // ######################################################################

    always_comb begin
        sb_line_t line;
        sb_line_t base;
        logic     lookup;
        logic     clear;
        logic     finish;
        logic     refill;
        for (int p = 0; p < 2; p++) begin
            rin_f[p]       = r_f[p];
            rin_f[p].wen   = 1'b0;
            rin_f[p].ready = 1'b0;
            rin_f[p].rdata = '0;
            start[p] = 1'b0;
            work[p]  = '0;
            line   = array_out.rdata[p];
            base   = line;
            lookup = 1'b0;
            clear  = 1'b0;
            finish = 1'b0;
            refill = 1'b0;

            if (r_f[p].wait_ret) begin
                if (ret[p]) begin
                    rin_f[p].wait_ret = 1'b0;
                    clear  = r_f[p].fence;    // the victim is written so the line is dropped.
                    finish = ~r_f[p].fence;
                    refill = ~r_f[p].fence;
                    base   = fill[p];
                end
            end else if (r_f[p].fence) begin
                if (line.valid && line.dirty) begin
                    if (back_idle) begin
                        start[p] = 1'b1;
                        work[p].back      = 1'b1;
                        work[p].vict_addr = {line.tag, 3'b000};
                        work[p].vict_data = line.data;
                        rin_f[p].wait_ret = 1'b1;
                    end
                end else begin
                    clear = 1'b1;
                end
            end else if (r_f[p].retry) begin
                lookup = 1'b1;
            end else if (req[p].valid) begin
                rin_f[p].addr  = req[p].addr;
                rin_f[p].data  = req[p].wdata;
                rin_f[p].strb  = req[p].strb;
                rin_f[p].fence = req[p].fence;
                rin_f[p].walk  = '0;
                lookup = ~req[p].fence;
            end

            if (lookup) begin
                if (line.valid && line.tag == rin_f[p].addr[31:3]) begin
                    finish = 1'b1;
                    rin_f[p].retry = 1'b0;
                end else if (back_idle) begin
                    start[p] = 1'b1;
                    work[p].miss      = 1'b1;
                    work[p].back      = line.valid & line.dirty;
                    work[p].fill_addr = {rin_f[p].addr[31:3], 3'b000};
                    work[p].vict_addr = {line.tag, 3'b000};
                    work[p].vict_data = line.data;
                    rin_f[p].retry    = 1'b0;
                    rin_f[p].wait_ret = 1'b1;
                end else begin
                    rin_f[p].retry = 1'b1;
                end
            end

            if (clear) begin
                rin_f[p].wen   = 1'b1;
                rin_f[p].waddr = r_f[p].walk;
                rin_f[p].wline = '0;
                if (r_f[p].walk == '1) begin
                    rin_f[p].fence = 1'b0;
                    rin_f[p].ready = 1'b1;   // last entry cleared.
                end else begin
                    rin_f[p].walk = r_f[p].walk + 1'b1;
                end
            end

            if (finish) begin
                rin_f[p].wline = base;
                for (int b = 0; b < 8; b++) begin
                    if (rin_f[p].strb[b]) begin
                        rin_f[p].wline.data[8*b +: 8] = rin_f[p].data[8*b +: 8];
                    end
                end
                rin_f[p].wline.dirty = base.dirty | (|rin_f[p].strb);
                rin_f[p].wen   = refill | (|rin_f[p].strb);  // load hits leave the line alone.
                rin_f[p].waddr = rin_f[p].addr[`SB_INDEX_WIDTH+2:3];
                rin_f[p].ready = 1'b1;
                rin_f[p].rdata = rin_f[p].wline.data;
            end
        end
    end

    // ######################################################################
    // back stage
    // ######################################################################

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rin_b[p] = r_b[p];
            if (mrsp[p].ready) begin
                if (r_b[p].back) begin
                    rin_b[p].back = 1'b0;
                end else begin
                    rin_b[p].miss = 1'b0;
                end
            end
            if (start[p]) begin
                rin_b[p] = work[p];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            prsp[p].ready = r_f[p].ready;
            prsp[p].rdata = r_f[p].rdata;
            mreq[p].valid = r_b[p].miss | r_b[p].back;
            mreq[p].store = r_b[p].back;
            mreq[p].addr  = r_b[p].back ? r_b[p].vict_addr : r_b[p].fill_addr;
            mreq[p].wdata = r_b[p].back ? r_b[p].vict_data : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            r_f <= '0;
            r_b <= '0;
        end else begin
            r_f <= rin_f;
            r_b <= rin_b;
        end
    end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/1ps

module store_buffer (
    input  logic                       clock,
    input  logic                       reset,
    input  store_buffer_pkg::sb_req_t  port0_req,
    input  store_buffer_pkg::sb_req_t  port1_req,
    output store_buffer_pkg::sb_rsp_t  port0_rsp,
    output store_buffer_pkg::sb_rsp_t  port1_rsp,
    input  store_buffer_pkg::mem_rsp_t mem0_rsp,
    input  store_buffer_pkg::mem_rsp_t mem1_rsp,
    output store_buffer_pkg::mem_req_t mem0_req,
    output store_buffer_pkg::mem_req_t mem1_req
);
    import store_buffer_pkg::*;

    sb_array_in_t  array_in;
    sb_array_out_t array_out;

    store_buffer_array i_array (
        .clock     (clock),
        .array_in  (array_in),
        .array_out (array_out)
    );

    store_buffer_ctrl i_ctrl (
        .clock     (clock),
        .reset     (reset),
        .port0_req (port0_req),
        .port1_req (port1_req),
        .port0_rsp (port0_rsp),
        .port1_rsp (port1_rsp),
        .array_out (array_out),
        .array_in  (array_in),
        .mem0_rsp  (mem0_rsp),
        .mem1_rsp  (mem1_rsp),
        .mem0_req  (mem0_req),
        .mem1_req  (mem1_req)
    );

endmodule

// File: verif/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] SEED = 32'd92672
) (
    input  logic                       clock,
    input  store_buffer_pkg::mem_req_t req,
    output store_buffer_pkg::mem_rsp_t rsp,
    input  store_buffer_pkg::mem_req_t write_in,   // stores seen on the other port.
    output store_buffer_pkg::mem_req_t write_out
);
    import store_buffer_pkg::*;

    logic [7:0]  image [256];
    logic [31:0] state = SEED;
    logic [1:0]  delay = 2'd1;
    mem_rsp_t    rsp_q = '0;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int a = 0; a < 256; a++) begin
            image[a] = 8'(a * 37 + 8'hc3);
        end
    end

    assign rsp = rsp_q;

    // a store lands on both images at the edge that ends its ready cycle.
    assign write_out = '{valid: rsp_q.ready & req.store, store: 1'b1,
                         addr: req.addr, wdata: req.wdata};

    always @(posedge clock) begin
        rsp_q <= '0;
        for (int b = 0; b < 8; b++) begin
            if (write_out.valid) image[{write_out.addr[7:3], b[2:0]}] <= write_out.wdata[8*b +: 8];
            if (write_in.valid) image[{write_in.addr[7:3], b[2:0]}] <= write_in.wdata[8*b +: 8];
        end
        if (req.valid && !rsp_q.ready) begin
            if (delay == 2'd0) begin
                rsp_q.ready <= 1'b1;
                for (int b = 0; b < 8; b++) begin
                    rsp_q.rdata[8*b +: 8] <= image[{req.addr[7:3], b[2:0]}];
                end
                state <= lcg_step(state);
                delay <= state[17:16];   // 0 to 3 extra cycles.
            end else begin
                delay <= delay - 2'd1;
            end
        end
    end

endmodule

// File: verif/store_buffer_tb.sv
`timescale 1ns/1ps
`include "store_buffer_config.svh"

module store_buffer_tb;
    import store_buffer_pkg::*;

    localparam int PERIOD   = 40;
    localparam int WORST    = `SB_DEPTH * 8 + 16;  // cycles for a fence with every line dirty.
    localparam int REQUESTS = 17;

    logic        clock = 1'b0;
    logic        reset = 1'b0;
    sb_req_t     port_req [2];
    sb_rsp_t     port_rsp [2];
    mem_req_t    mem_req [2];
    mem_rsp_t    mem_rsp [2];
    mem_req_t    mem_write [2];
    mem_req_t    mem_log [2][$];   // finished memory transactions per port.
    logic [7:0]  golden [256];
    logic [31:0] seed = 32'd92672;

    store_buffer i_store_buffer (
        .clock     (clock),
        .reset     (reset),
        .port0_req (port_req[0]),
        .port1_req (port_req[1]),
        .port0_rsp (port_rsp[0]),
        .port1_rsp (port_rsp[1]),
        .mem0_rsp  (mem_rsp[0]),
        .mem1_rsp  (mem_rsp[1]),
        .mem0_req  (mem_req[0]),
        .mem1_req  (mem_req[1])
    );

    mem_model i_mem0 (
        .clock     (clock),
        .req       (mem_req[0]),
        .rsp       (mem_rsp[0]),
        .write_in  (mem_write[1]),
        .write_out (mem_write[0])
    );

    mem_model i_mem1 (
        .clock     (clock),
        .req       (mem_req[1]),
        .rsp       (mem_rsp[1]),
        .write_in  (mem_write[0]),
        .write_out (mem_write[1])
    );

    initial begin
        forever #(PERIOD / 2) clock = ~clock;
    end

    always @(negedge clock) begin
        for (int p = 0; p < 2; p++) begin
            if (mem_req[p].valid && mem_rsp[p].ready) mem_log[p].push_back(mem_req[p]);
        end
    end

    initial begin
        #((REQUESTS + 4) * WORST * PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    // ######################################################################
    // helpers
    // ######################################################################

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [63:0] golden_line(input logic [31:0] addr);
        logic [63:0] line;
        for (int b = 0; b < 8; b++) line[8*b +: 8] = golden[{addr[7:3], b[2:0]}];
        return line;
    endfunction

    task automatic random_store(output logic [63:0] data, output logic [7:0] strb);
        seed = lcg_step(seed);
        data[31:0] = seed;
        seed = lcg_step(seed);
        data[63:32] = seed;
        seed = lcg_step(seed);
        strb = seed[27:20] | 8'h01;   // at least one byte.
    endtask

    // one request on port p, then wait for its ready pulse.
    task automatic access(input int p, input logic fence, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] strb,
                          output logic [63:0] rdata, output int cycles);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) golden[{addr[7:3], b[2:0]}] = wdata[8*b +: 8];
        end
        @(posedge clock);
        port_req[p] <= '{valid: 1'b1, fence: fence, addr: addr, wdata: wdata, strb: strb};
        @(posedge clock);
        port_req[p] <= '0;
        cycles = 1;
        @(negedge clock);
        while (!port_rsp[p].ready) begin
            if (cycles >= WORST) fail_run($sformatf("port %0d never answered with ready", p));
            cycles++;
            @(negedge clock);
        end
        rdata = port_rsp[p].rdata;
    endtask

    task automatic check_quiet();
        for (int p = 0; p < 2; p++) begin
            check($sformatf("port%0d_rsp.ready", p), 64'(port_rsp[p].ready), 64'd0);
            check($sformatf("mem%0d_req.valid", p), 64'(mem_req[p].valid), 64'd0);
        end
    endtask

    task automatic check_image();
        for (int a = 0; a < 256; a++) begin
            check($sformatf("mem0 image[%0h]", a), 64'(i_mem0.image[a]), 64'(golden[a]));
            check($sformatf("mem1 image[%0h]", a), 64'(i_mem1.image[a]), 64'(golden[a]));
        end
    endtask

    // ######################################################################
    // directed tests
    // ######################################################################

    task automatic reset_test();
        for (int c = 0; c < 4; c++) begin
            @(posedge clock);
            if (c == 2) reset <= 1'b1;
            @(negedge clock);
            check_quiet();
        end
    endtask

    task automatic load_miss_test();
        logic [63:0] data;
        int          cycles;
        mem_log[0].delete();
        access(0, 1'b0, 32'h0c, 64'h0, 8'h00, data, cycles);
        check("port0_rsp.rdata", data, golden_line(32'h08));
        check("mem0 request count", 64'(mem_log[0].size()), 64'd1);
        check("mem0_req.store", 64'(mem_log[0][0].store), 64'd0);
        check("mem0_req.addr", 64'(mem_log[0][0].addr), 64'h08);
        mem_log[0].delete();
        access(0, 1'b0, 32'h08, 64'h0, 8'h00, data, cycles);
        check("port0_rsp.rdata", data, golden_line(32'h08));
        check("port0 hit latency", 64'(cycles), 64'd1);
        check("mem0 request count", 64'(mem_log[0].size()), 64'd0);
    endtask

    task automatic store_merge_test();
        logic [63:0] data;
        logic [7:0]  strb;
        int          cycles;
        mem_log[0].delete();
        random_store(data, strb);
        access(0, 1'b0, 32'h08, data, strb, data, cycles);
        check("port0 store hit latency", 64'(cycles), 64'd1);
        access(0, 1'b0, 32'h08, 64'h0, 8'h00, data, cycles);
        check("port0_rsp.rdata", data, golden_line(32'h08));
        check("mem0 request count", 64'(mem_log[0].size()), 64'd0);
    endtask

    task automatic eviction_test();
        logic [63:0] data;
        int          cycles;
        mem_log[0].delete();
        access(0, 1'b0, 32'h48, 64'h0, 8'h00, data, cycles);   // same index as 0x08.
        check("port0_rsp.rdata", data, golden_line(32'h48));
        check("mem0 request count", 64'(mem_log[0].size()), 64'd2);
        check("mem0_req.store", 64'(mem_log[0][0].store), 64'd1);
        check("mem0_req.addr", 64'(mem_log[0][0].addr), 64'h08);
        check("mem0_req.wdata", mem_log[0][0].wdata, golden_line(32'h08));
        check("mem0_req.store", 64'(mem_log[0][1].store), 64'd0);
        check("mem0_req.addr", 64'(mem_log[0][1].addr), 64'h48);
        check_image();
    endtask

    task automatic fence_test();
        logic [31:0] addrs [4] = '{32'h10, 32'h1c, 32'h20, 32'hbc};
        logic [63:0] data;
        logic [7:0]  strb;
        int          cycles;
        for (int i = 0; i < 4; i++) begin
            random_store(data, strb);
            access(0, 1'b0, addrs[i], data, strb, data, cycles);
        end
        access(0, 1'b1, 32'h0, 64'h0, 8'h00, data, cycles);
        check_image();
        mem_log[0].delete();
        access(0, 1'b0, 32'h10, 64'h0, 8'h00, data, cycles);
        check("port0_rsp.rdata", data, golden_line(32'h10));
        check("mem0 request count", 64'(mem_log[0].size()), 64'd1);
        check("mem0_req.store", 64'(mem_log[0][0].store), 64'd0);
        check("mem0_req.addr", 64'(mem_log[0][0].addr), 64'h10);
    endtask

    task automatic dual_port_test();
        logic [63:0] d0, d1, data;
        logic [7:0]  strb;
        int          c0, c1;
        random_store(data, strb);
        mem_log[1].delete();
        fork
            access(0, 1'b0, 32'h10, 64'h0, 8'h00, d0, c0);   // hit.
            access(1, 1'b0, 32'h2c, data, strb, d1, c1);      // store miss.
        join
        check("port0_rsp.rdata", d0, golden_line(32'h10));
        check("port0 hit latency", 64'(c0), 64'd1);
        check("mem1 request count", 64'(mem_log[1].size()), 64'd1);
        check("mem1_req.store", 64'(mem_log[1][0].store), 64'd0);
        check("mem1_req.addr", 64'(mem_log[1][0].addr), 64'h28);
        fork
            access(0, 1'b0, 32'he4, 64'h0, 8'h00, d0, c0);
            access(1, 1'b0, 32'h28, 64'h0, 8'h00, d1, c1);
        join
        check("port0_rsp.rdata", d0, golden_line(32'he0));
        check("port1_rsp.rdata", d1, golden_line(32'h28));
        check("port1 hit latency", 64'(c1), 64'd1);
        // both miss and port 1 evicts its dirty line at 0x28.
        mem_log[0].delete();
        mem_log[1].delete();
        fork
            access(0, 1'b0, 32'h38, 64'h0, 8'h00, d0, c0);
            access(1, 1'b0, 32'h68, 64'h0, 8'h00, d1, c1);
        join
        check("port0_rsp.rdata", d0, golden_line(32'h38));
        check("port1_rsp.rdata", d1, golden_line(32'h68));
        check("mem0 request count", 64'(mem_log[0].size()), 64'd1);
        check("mem1 request count", 64'(mem_log[1].size()), 64'd2);
        check("mem1_req.store", 64'(mem_log[1][0].store), 64'd1);
        check("mem1_req.addr", 64'(mem_log[1][0].addr), 64'h28);
        check("mem1_req.wdata", mem_log[1][0].wdata, golden_line(32'h28));
        check("mem1_req.store", 64'(mem_log[1][1].store), 64'd0);
        check("mem1_req.addr", 64'(mem_log[1][1].addr), 64'h68);
        check_image();
    endtask

    initial begin
        port_req[0] = '0;
        port_req[1] = '0;
        for (int a = 0; a < 256; a++) golden[a] = 8'(a * 37 + 8'hc3);
        reset_test();
        load_miss_test();
        store_merge_test();
        eviction_test();
        fence_test();
        dual_port_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: store_buffer.f
+incdir+include
hw/store_buffer_pkg.sv
hw/store_buffer_array.sv
hw/store_buffer_ctrl.sv
hw/store_buffer.sv
verif/mem_model.sv
verif/store_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module store_buffer_tb \
    -f store_buffer.f -o store_buffer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/store_buffer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -F -q "*** FAILED ***" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

exit 0
